//--- files.f
+incdir+.
mont_pkg.sv
mont_pe_first.sv
mont_pe.sv
mont_pe_array.sv
mont_ctrl.sv
mont_mult_top.sv
tb_mont_mult.sv

//--- mont_ctrl.sv
// Controller FSM: word inverse, a-word feeding, drain, final subtraction and done pulse
`include "mont_macros.svh"

module mont_ctrl (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    start_i,
    input  mont_pkg::mont_req_t     req_i,
    input  mont_pkg::mont_operand_t s_words_i,
    input  logic                    carry_i,
    output logic                    clear_o,
    output logic                    odd_o,
    output mont_pkg::mont_word_t    a_word_o,
    output mont_pkg::mont_operand_t b_o,
    output mont_pkg::mont_operand_t p_o,
    output mont_pkg::mont_word_t    n_prime_o,
    output mont_pkg::mont_operand_t result_o,
    output logic                    done_o,
    output logic                    busy_o
);

    import mont_pkg::*;

    localparam int N     = `MONT_NUM_WORDS;
    localparam int W     = N * `MONT_RADIX;
    localparam int CNT_W = 8;

    mont_state_e        state;
    logic [CNT_W-1:0]   cnt;
    mont_operand_t      a_q;
    mont_word_t         inv_q;
    mont_word_t         inv_chk;
    logic [W:0]         full_sum;
    logic [W:0]         diff;

    // ------------------------------------------------------------------------
    // FSM and operand registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= ST_IDLE;
            cnt     <= '0;
            clear_o <= 1'b0;
        end else begin
            clear_o <= 1'b0;
            cnt     <= cnt + 1'b1;
            case (state)
                ST_IDLE: begin
                    cnt <= '0;
                    if (start_i) begin
                        clear_o <= 1'b1;
                        state   <= ST_INV;
                    end
                end
                ST_INV: begin
                    if (cnt == CNT_W'(`MONT_INV_STEPS - 1)) begin
                        cnt   <= '0;
                        state <= ST_FEED;
                    end
                end
                ST_FEED: begin
                    if (cnt == CNT_W'(2 * N - 1)) begin
                        cnt   <= '0;
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    if (cnt == CNT_W'(2 * N - 1)) begin
                        state <= ST_REDUCE;
                    end
                end
                ST_REDUCE: state <= ST_DONE;
                default:   state <= ST_IDLE;
            endcase
        end
    end

    // Request words and word inverse
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start_i) begin
            a_q   <= req_i.a;
            b_o   <= req_i.b;
            p_o   <= req_i.p;
            // p0 is its own inverse mod 8 which gives three good bits
            inv_q <= req_i.p[0];
        end else if (state == ST_INV) begin
            // Newton step x = x * (2 - p0 * x) doubles the correct bits
            inv_q <= inv_q * (mont_word_t'(2) - p_o[0] * inv_q);
        end
    end

    // ------------------------------------------------------------------------
    // Final subtraction
    // ------------------------------------------------------------------------
    assign full_sum = {carry_i, s_words_i};
    assign diff     = full_sum - {1'b0, p_o};

    always_ff @(posedge clk) begin
        if (state == ST_REDUCE) begin
            // Borrow clear means the sum was at least p
            result_o <= diff[W] ? s_words_i : diff[W-1:0];
        end
    end

    // ------------------------------------------------------------------------
    // Outputs
    // ------------------------------------------------------------------------
    assign n_prime_o = -inv_q;
    // First cycle of each pair carries a new a-word
    assign odd_o     = (state == ST_FEED) && !cnt[0];
    assign a_word_o  = a_q[cnt[CNT_W-1:1] % N];
    assign done_o    = (state == ST_DONE);
    assign busy_o    = (state != ST_IDLE);
    assign inv_chk   = n_prime_o * p_o[0];

    a_p_odd : assert property (
        @(posedge clk) disable iff (!reset_n)
        start_i && state == ST_IDLE |-> req_i.p[0][0]
    );

    a_inverse_ok : assert property (
        @(posedge clk) disable iff (!reset_n)
        state == ST_FEED |-> inv_chk == '1
    );

    a_done_pulse : assert property (
        @(posedge clk) disable iff (!reset_n)
        done_o |=> !done_o
    );

endmodule

//--- mont_macros.svh
// Word size, operand length and inverse iteration count for the Montgomery multiplier
`ifndef MONT_MACROS_SVH
`define MONT_MACROS_SVH

// Bits per word (16 or 32)
`define MONT_RADIX 16

// Words per operand (2 or more)
`define MONT_NUM_WORDS 4

// Newton steps for the word inverse equal log2 of the radix
`define MONT_INV_STEPS 4

`endif

//--- mont_mult_top.sv
// Top level: controller and systolic element array
module mont_mult_top (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    start_i,
    input  mont_pkg::mont_req_t     req_i,
    output mont_pkg::mont_operand_t result_o,
    output logic                    done_o,
    output logic                    busy_o
);

    import mont_pkg::*;

    logic          clear;
    logic          odd;
    logic          carry;
    mont_word_t    a_word;
    mont_word_t    n_prime;
    mont_operand_t b_op;
    mont_operand_t p_op;
    mont_operand_t s_words;

    // Sequencing, inverse and final subtraction
    mont_ctrl u_ctrl (
        .clk       (clk),
        .reset_n   (reset_n),
        .start_i   (start_i),
        .req_i     (req_i),
        .s_words_i (s_words),
        .carry_i   (carry),
        .clear_o   (clear),
        .odd_o     (odd),
        .a_word_o  (a_word),
        .b_o       (b_op),
        .p_o       (p_op),
        .n_prime_o (n_prime),
        .result_o  (result_o),
        .done_o    (done_o),
        .busy_o    (busy_o)
    );

    // Word-serial datapath
    mont_pe_array u_array (
        .clk       (clk),
        .reset_n   (reset_n),
        .clear_i   (clear),
        .odd_i     (odd),
        .a_word_i  (a_word),
        .b_i       (b_op),
        .p_i       (p_op),
        .n_prime_i (n_prime),
        .s_words_o (s_words),
        .carry_o   (carry)
    );

endmodule

//--- mont_pe.sv
// Middle systolic element: accumulates a*b_j and m*p_j into the partial sum
module mont_pe #(
    // Set on the last element, which keeps the top sum bit in its own carry
    parameter bit TOP = 1'b0
) (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 clear_i,
    input  logic                 odd_i,
    input  mont_pkg::mont_link_t link_i,
    input  mont_pkg::mont_word_t b_i,
    input  mont_pkg::mont_word_t p_i,
    input  mont_pkg::mont_word_t s_i,
    output mont_pkg::mont_link_t link_o,
    output mont_pkg::mont_word_t s_o
);

    import mont_pkg::*;

    localparam int R  = $bits(mont_word_t);
    // Two products, a word, a carry and the top bit fit in 2R+2 bits
    localparam int TW = 2 * R + 2;

    logic [TW-1:0] prod_ab;
    logic [TW-1:0] prod_mp;
    logic [TW-1:0] top_add;
    logic [TW-1:0] t_sum;

    // ------------------------------------------------------------------------
    // Word accumulation
    // ------------------------------------------------------------------------

    assign prod_ab = TW'(link_i.a) * TW'(b_i);
    assign prod_mp = TW'(link_i.m) * TW'(p_i);

    // On the last element bit R of its previous carry is sum word n at weight 2^R
    assign top_add = TOP ? (TW'(link_o.c[R]) << R) : '0;

    always_comb begin
        t_sum = TW'(s_i) + prod_ab;
        t_sum = t_sum + prod_mp;
        t_sum = t_sum + TW'(link_i.c);
        t_sum = t_sum + top_add;
    end

    // ------------------------------------------------------------------------
    // Registers
    // ------------------------------------------------------------------------

    // Low word goes back to element j-1 and the high part forward as carry
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            link_o <= '0;
            s_o    <= '0;
        end else if (clear_i) begin
            link_o <= '0;
            s_o    <= '0;
        end else if (odd_i) begin
            // a and m move on with one cycle of delay
            link_o.a <= link_i.a;
            link_o.m <= link_i.m;
            link_o.c <= t_sum[2*R:R];
            s_o      <= t_sum[R-1:0];
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // Sum stays below 2^(2R+1) since the running value stays below 2p
    a_no_overflow : assert property (
        @(posedge clk) disable iff (!reset_n)
        odd_i && !clear_i |-> t_sum[TW-1] == 1'b0
    );

endmodule

//--- mont_pe_array.sv
// Systolic chain of one first element and NUM_WORDS-1 middle elements
`include "mont_macros.svh"

module mont_pe_array (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    clear_i,
    input  logic                    odd_i,
    input  mont_pkg::mont_word_t    a_word_i,
    input  mont_pkg::mont_operand_t b_i,
    input  mont_pkg::mont_operand_t p_i,
    input  mont_pkg::mont_word_t    n_prime_i,
    output mont_pkg::mont_operand_t s_words_o,
    output logic                    carry_o
);

    import mont_pkg::*;

    localparam int N = `MONT_NUM_WORDS;
    localparam int R = `MONT_RADIX;

    mont_link_t        links [N];
    // Partial-sum word that element j returns to element j-1
    mont_word_t        s_fb  [1:N];
    // Active strobe of each element lags its left neighbour by one cycle
    logic [N-1:0]      act;

    assign act[0] = odd_i;
    // Last element feeds back its own carry word
    assign s_fb[N] = links[N-1].c[R-1:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            act[N-1:1] <= '0;
        end else if (clear_i) begin
            act[N-1:1] <= '0;
        end else begin
            act[N-1:1] <= act[N-2:0];
        end
    end

    // ------------------------------------------------------------------------
    // Element chain
    // ------------------------------------------------------------------------

    mont_pe_first u_pe0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .clear_i   (clear_i),
        .odd_i     (act[0]),
        .a_i       (a_word_i),
        .b_i       (b_i[0]),
        .p_i       (p_i[0]),
        .n_prime_i (n_prime_i),
        .s_i       (s_fb[1]),
        .link_o    (links[0])
    );

    for (genvar j = 1; j < N; j++) begin : g_pe
        mont_pe #(
            .TOP (j == N - 1)
        ) u_pe (
            .clk     (clk),
            .reset_n (reset_n),
            .clear_i (clear_i),
            .odd_i   (act[j]),
            .link_i  (links[j-1]),
            .b_i     (b_i[j]),
            .p_i     (p_i[j]),
            .s_i     (s_fb[j+1]),
            .link_o  (links[j]),
            .s_o     (s_fb[j])
        );
        // Element j holds result word j-1
        assign s_words_o[j-1] = s_fb[j];
    end

    // Top word and extra bit come from the final carry
    assign s_words_o[N-1] = s_fb[N];
    assign carry_o        = links[N-1].c[R];

endmodule

//--- mont_pe_first.sv
// First systolic element: quotient digit, low word cancellation and link registers
module mont_pe_first (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 clear_i,
    input  logic                 odd_i,
    input  mont_pkg::mont_word_t a_i,
    input  mont_pkg::mont_word_t b_i,
    input  mont_pkg::mont_word_t p_i,
    input  mont_pkg::mont_word_t n_prime_i,
    input  mont_pkg::mont_word_t s_i,
    output mont_pkg::mont_link_t link_o
);

    import mont_pkg::*;

    localparam int R  = $bits(mont_word_t);
    // Wide enough for s + a*b + m*p without overflow
    localparam int TW = 2 * R + 1;

    logic [TW-1:0]  u_sum;
    logic [TW-1:0]  v_sum;
    logic [2*R-1:0] m_prod;
    mont_word_t     m_val;

    // ------------------------------------------------------------------------
    // Quotient digit
    // ------------------------------------------------------------------------

    // Partial sum word 0 plus a times b0
    assign u_sum = TW'(s_i) + TW'(a_i) * TW'(b_i);

    // m makes the low word vanish once m*p0 is added
    assign m_prod = u_sum[R-1:0] * n_prime_i;
    assign m_val  = m_prod[R-1:0];

    // Low word of v is zero and the high part is the carry
    assign v_sum = u_sum + TW'(m_val) * TW'(p_i);

    // ------------------------------------------------------------------------
    // Link registers
    // ------------------------------------------------------------------------

    // Update only in the active cycle of each iteration
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            link_o <= '0;
        end else if (clear_i) begin
            link_o <= '0;
        end else if (odd_i) begin
            link_o.a <= a_i;
            link_o.m <= m_val;
            link_o.c <= v_sum[TW-1:R];
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // n_prime from the controller must cancel the low word of the sum
    a_low_word_zero : assert property (
        @(posedge clk) disable iff (!reset_n)
        odd_i && !clear_i |-> v_sum[R-1:0] == '0
    );

endmodule

//--- mont_pkg.sv
// Package with word, operand, link and request types and the controller state enum
`include "mont_macros.svh"

package mont_pkg;

    // One radix word
    typedef logic [`MONT_RADIX-1:0] mont_word_t;

    // Whole operand, least significant word at index 0
    typedef mont_word_t [`MONT_NUM_WORDS-1:0] mont_operand_t;

    // Request sampled on start
    typedef struct packed {
        mont_operand_t a;
        mont_operand_t b;
        mont_operand_t p;
    } mont_req_t;

    // Element j to element j+1
    typedef struct packed {
        mont_word_t             a;
        mont_word_t             m;
        logic [`MONT_RADIX:0]   c;
    } mont_link_t;

    // Controller phases
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INV,
        ST_FEED,
        ST_DRAIN,
        ST_REDUCE,
        ST_DONE
    } mont_state_e;

endpackage

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the Montgomery multiplier testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f files.f \
    --top-module tb_mont_mult \
    -o Vtb_mont_mult

./obj_dir/Vtb_mont_mult | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"

//--- tb_mont_tasks.svh
// Testbench tasks: request driving, bounded waits, typed compares and test bookkeeping
`ifndef TB_MONT_TASKS_SVH
`define TB_MONT_TASKS_SVH

// --------------------------------------------------------------------------
// Request and waits
// --------------------------------------------------------------------------

// Waits for idle, then pulses start for one cycle with the request
task automatic drive_request(input string name, input mont_req_t req);
    int n;
    for (n = 0; n < TIMEOUT && busy_o; n++) begin
        @(negedge clk);
    end
    if (busy_o) begin
        $display("%s: DUT still busy after %0d cycles, start not issued", name, TIMEOUT);
        err_count++;
    end
    req_i   = req;
    start_i = 1'b1;
    @(negedge clk);
    start_i = 1'b0;
endtask

// Samples on falling edges until done_o, flags any busy_o drop on the way
task automatic wait_done(input string name, output bit ok, output bit busy_gap);
    int n;
    ok       = 1'b0;
    busy_gap = 1'b0;
    for (n = 0; n < TIMEOUT; n++) begin
        if (done_o) begin
            ok = 1'b1;
            break;
        end
        if (!busy_o) begin
            busy_gap = 1'b1;
        end
        @(negedge clk);
    end
    if (!ok) begin
        $display("%s: no done pulse within %0d cycles", name, TIMEOUT);
        err_count++;
    end
endtask

// --------------------------------------------------------------------------
// Typed compares
// --------------------------------------------------------------------------
task automatic check_operand(input string name, input mont_operand_t exp,
                             input mont_operand_t act);
    check_count++;
    if (act !== exp) begin
        $display("[ERROR] %s expected %h actual %h", name, exp, act);
        err_count++;
    end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
    check_count++;
    if (act !== exp) begin
        $display("[ERROR] %s expected %b actual %b", name, exp, act);
        err_count++;
    end
endtask

// One summary line per finished test
task automatic end_test(input string name, input int errs_before);
    test_count++;
    $display("test %s finished, %0d errors", name, err_count - errs_before);
endtask

`endif

//--- tb_mont_mult.sv
// Testbench top: clock, reset, DUT, LFSR, reference model and directed tests
`include "mont_macros.svh"

module tb_mont_mult;

    import mont_pkg::*;

    localparam int          W         = `MONT_NUM_WORDS * `MONT_RADIX;
    localparam int          TIMEOUT   = 400;
    // Right-shifting form of x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic          clk = 1'b0;
    logic          reset_n;
    logic          start_i;
    mont_req_t     req_i;
    mont_operand_t result_o;
    logic          done_o;
    logic          busy_o;

    logic [31:0]   lfsr_state  = 32'h261f_e7e4;
    int            err_count   = 0;
    int            check_count = 0;
    int            test_count  = 0;

    always #5 clk = ~clk;

    mont_mult_top dut0 (
        .clk      (clk),
        .reset_n  (reset_n),
        .start_i  (start_i),
        .req_i    (req_i),
        .result_o (result_o),
        .done_o   (done_o),
        .busy_o   (busy_o)
    );

    `include "tb_mont_tasks.svh"

    // ----------------------------------------------------------------------
    // Stimulus source and reference model
    // ----------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ LFSR_TAPS;
        end
        return n;
    endfunction

    // One LFSR step per bit
    task automatic take_bits(input int nbits, output logic [127:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            v[i]       = lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Odd modulus with the top bit set
    task automatic pick_modulus(output logic [127:0] p);
        take_bits(W, p);
        p[0]   = 1'b1;
        p[W-1] = 1'b1;
    endtask

    task automatic pick_below(input logic [127:0] p, output logic [127:0] v);
        take_bits(W, v);
        v = v % p;
    endtask

    // Bit-serial a*b*2^-W mod p
    function automatic logic [127:0] mont_ref(input logic [127:0] a, input logic [127:0] b,
                                              input logic [127:0] p);
        logic [127:0] s;
        s = '0;
        for (int i = 0; i < W; i++) begin
            if (a[i]) begin
                s = s + b;
            end
            if (s[0]) begin
                s = s + p;
            end
            s = s >> 1;
        end
        if (s >= p) begin
            s = s - p;
        end
        return s;
    endfunction

    // 2^(2W) mod p by doubling
    function automatic logic [127:0] r2_mod(input logic [127:0] p);
        logic [127:0] r;
        r = 128'd1;
        for (int i = 0; i < 2 * W; i++) begin
            r = r << 1;
            if (r >= p) begin
                r = r - p;
            end
        end
        return r;
    endfunction

    // Full request and wait with the result read on the done cycle
    task automatic run_mult(input string name, input logic [127:0] a, input logic [127:0] b,
                            input logic [127:0] p, output mont_operand_t res,
                            output bit busy_gap);
        mont_req_t req;
        bit        ok;
        req.a = mont_operand_t'(a);
        req.b = mont_operand_t'(b);
        req.p = mont_operand_t'(p);
        drive_request(name, req);
        wait_done(name, ok, busy_gap);
        res = result_o;
    endtask

    // ----------------------------------------------------------------------
    // Directed tests
    // ----------------------------------------------------------------------
    task automatic test_unit();
        logic [127:0]  p;
        mont_operand_t res;
        bit            gap;
        int            e0;
        e0     = err_count;
        p      = 128'hd3c1_9a5e_7b20_46f1_c4e8_1f93_a76d_5b09;
        p[0]   = 1'b1;
        p[W-1] = 1'b1;
        p      = p & ((128'd1 << W) - 128'd1);
        run_mult("unit", 128'd1, 128'd1, p, res, gap);
        // 1*1*R^-1 is the inverse of R
        check_operand("unit", mont_operand_t'(mont_ref(128'd1, 128'd1, p)), res);
        end_test("unit", e0);
    endtask

    task automatic test_random();
        logic [127:0]  a;
        logic [127:0]  b;
        logic [127:0]  p;
        mont_operand_t res;
        bit            gap;
        int            e0;
        e0 = err_count;
        for (int k = 0; k < 20; k++) begin
            pick_modulus(p);
            pick_below(p, a);
            pick_below(p, b);
            run_mult("random", a, b, p, res, gap);
            check_operand("random", mont_operand_t'(mont_ref(a, b, p)), res);
        end
        end_test("random", e0);
    endtask

    task automatic test_edge();
        logic [127:0]  pmax;
        logic [127:0]  p;
        logic [127:0]  b;
        mont_operand_t res;
        bit            gap;
        int            e0;
        e0   = err_count;
        pmax = (128'd1 << W) - 128'd1;
        // Largest operands with the largest modulus
        run_mult("edge_max", pmax - 1, pmax - 1, pmax, res, gap);
        check_operand("edge_max", mont_operand_t'(mont_ref(pmax - 1, pmax - 1, pmax)), res);
        pick_modulus(p);
        run_mult("edge_pm1", p - 1, p - 1, p, res, gap);
        check_operand("edge_pm1", mont_operand_t'(mont_ref(p - 1, p - 1, p)), res);
        pick_below(pmax, b);
        run_mult("edge_mix", pmax - 1, b, pmax, res, gap);
        check_operand("edge_mix", mont_operand_t'(mont_ref(pmax - 1, b, pmax)), res);
        end_test("edge", e0);
    endtask

    task automatic test_zero();
        logic [127:0]  b;
        logic [127:0]  p;
        mont_operand_t res;
        bit            gap;
        int            e0;
        e0 = err_count;
        pick_modulus(p);
        pick_below(p, b);
        run_mult("zero", 128'd0, b, p, res, gap);
        check_operand("zero", '0, res);
        check_flag("zero_busy_held", 1'b0, gap);
        @(negedge clk);
        check_flag("zero_done_pulse", 1'b0, done_o);
        check_flag("zero_busy_after_done", 1'b0, busy_o);
        end_test("zero", e0);
    endtask

    // Back-to-back products where the second one undoes the R^-1
    task automatic test_round_trip();
        logic [127:0]  a;
        logic [127:0]  b;
        logic [127:0]  p;
        mont_operand_t x;
        mont_operand_t res;
        bit            gap;
        int            e0;
        e0 = err_count;
        for (int k = 0; k < 3; k++) begin
            pick_modulus(p);
            pick_below(p, a);
            pick_below(p, b);
            run_mult("trip_first", a, b, p, x, gap);
            check_operand("trip_first", mont_operand_t'(mont_ref(a, b, p)), x);
            run_mult("trip_second", 128'(x), r2_mod(p), p, res, gap);
            check_operand("trip_second", mont_operand_t'((a * b) % p), res);
        end
        end_test("round_trip", e0);
    endtask

    // ----------------------------------------------------------------------
    // Sequence
    // ----------------------------------------------------------------------
    initial begin
        reset_n = 1'b0;
        start_i = 1'b0;
        req_i   = '0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);
        test_unit();
        test_random();
        test_edge();
        test_zero();
        test_round_trip();
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
